/* build.f */
rtl/ddr_phy_pkg.sv
rtl/fr_cycle_shifter.sv
rtl/fr_cycle_extender.sv
rtl/write_path_pipe.sv
rtl/write_shift_cfg.sv
rtl/write_datapath.sv
rtl/phy_write_top.sv
tb/phy_write_properties.sv
tb/phy_write_tb.sv

/* Makefile */
# Verilator build and run of the phy write path testbench

SIM := obj_dir/Vphy_write_tb

all: run

$(SIM): build.f $(shell cat build.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module phy_write_tb -f build.f

run: $(SIM)
	$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* tb/phy_write_tb.sv */
// testbench for the ddr3 phy write path top level
// directed tests against a slot-history reference model
module phy_write_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import ddr_phy_pkg::*;

	localparam int PIPE_STAGES    = 2;
	localparam int TIMEOUT_CYCLES = 2000;

	logic                      pll_afi_clk;
	logic                      arst_n;
	logic [AFI_DATA_WIDTH-1:0] afi_wdata;
	logic [AFI_DQS_WIDTH-1:0]  afi_wdata_valid;
	logic [AFI_DM_WIDTH-1:0]   afi_dm;
	logic [AFI_DQS_WIDTH-1:0]  afi_dqs_en;
	logic [AFI_DQS_WIDTH-1:0]  force_oct_off;
	logic                      cfg_wr;
	logic [0:0]                cfg_group;
	shift_t                    cfg_shift;
	logic [AFI_DATA_WIDTH-1:0] phy_ddio_dq;
	logic [AFI_DM_WIDTH-1:0]   phy_ddio_wrdata_mask;
	logic [AFI_DQS_WIDTH-1:0]  phy_ddio_wrdata_en;
	logic [AFI_DQS_WIDTH-1:0]  phy_ddio_dqs_en;
	logic [AFI_DQS_WIDTH-1:0]  phy_ddio_oct_ena;

	// the reference model keeps one afi word per cycle since reset release
	afi_wr_t                  hist [0:2047];
	shift_t                   model_shift [MEM_WRITE_DQS_WIDTH];
	logic                     pend_wr;
	logic                     pend_grp;
	shift_t                   pend_shift;
	logic [AFI_DQS_WIDTH-1:0] force_now;
	logic [31:0]              rng_state;
	int cyc;
	int cycle_count;
	int test_checks;
	int test_errors;
	int total_checks;
	int total_errors;
	int tests_run;

	phy_write_top phy_write_top_inst (
		.pll_afi_clk          (pll_afi_clk),
		.arst_n               (arst_n),
		.afi_wdata            (afi_wdata),
		.afi_wdata_valid      (afi_wdata_valid),
		.afi_dm               (afi_dm),
		.afi_dqs_en           (afi_dqs_en),
		.force_oct_off        (force_oct_off),
		.cfg_wr               (cfg_wr),
		.cfg_group            (cfg_group),
		.cfg_shift            (cfg_shift),
		.phy_ddio_dq          (phy_ddio_dq),
		.phy_ddio_wrdata_mask (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en   (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en      (phy_ddio_dqs_en),
		.phy_ddio_oct_ena     (phy_ddio_oct_ena)
	);

	bind phy_write_top phy_write_properties phy_write_properties_inst (
		.pll_afi_clk        (pll_afi_clk),
		.arst_n             (arst_n),
		.afi_dqs_en         (afi_dqs_en),
		.afi_wdata_valid    (afi_wdata_valid),
		.force_oct_off      (force_oct_off),
		.phy_ddio_dqs_en    (phy_ddio_dqs_en),
		.phy_ddio_wrdata_en (phy_ddio_wrdata_en),
		.phy_ddio_oct_ena   (phy_ddio_oct_ena)
	);

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #50 pll_afi_clk = ~pll_afi_clk;
	end

	// the tests take roughly 250 cycles
	always @(posedge pll_afi_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("run did not complete within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ************************************************************
	// stimulus and reference model
	// ************************************************************

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic afi_wr_t random_word();
		afi_wr_t     w;
		logic [31:0] r;
		w.wdata = {next_random(), next_random(), next_random(), next_random()};
		r = next_random();
		w.dm = r[15:0];
		w.wdata_valid = r[23:16];
		w.dqs_en = r[31:24];
		return w;
	endfunction

	// returns the input dqs_en of group g at slot position p and zero before reset release
	function automatic logic dqs_at(input int p, input int g);
		if (p < 0)
			return 1'b0;
		else
			return hist[p / RATE_MULT].dqs_en[g + (p % RATE_MULT) * MEM_WRITE_DQS_WIDTH];
	endfunction

	// output slot q of group g carries input slot q - 4N - k
	function automatic ddio_wr_t expected_out(input int c);
		ddio_wr_t want;
		afi_wr_t  src;
		int       k;
		int       p;
		int       ps;
		logic     win;
		want = '0;
		for (int g = 0; g < MEM_WRITE_DQS_WIDTH; g++)
		begin
			k = int'(model_shift[g]);
			for (int s = 0; s < RATE_MULT; s++)
			begin
				p = RATE_MULT * (c - PIPE_STAGES) + s - k;
				win = dqs_at(p - 1, g) | dqs_at(p, g) | dqs_at(p + 1, g);
				want.oct_ena[g + s*MEM_WRITE_DQS_WIDTH] =
					~force_now[g + s*MEM_WRITE_DQS_WIDTH] & ~win;
				if (p >= 0)
				begin
					src = hist[p / RATE_MULT];
					ps = p % RATE_MULT;
					want.wrdata_en[g + s*MEM_WRITE_DQS_WIDTH] =
						src.wdata_valid[g + ps*MEM_WRITE_DQS_WIDTH];
					want.dqs_en[g + s*MEM_WRITE_DQS_WIDTH] = src.dqs_en[g + ps*MEM_WRITE_DQS_WIDTH];
					for (int b = 0; b < 2; b++)
					begin
						want.dq[g*DQ_GROUP_WIDTH + (2*s + b)*MEM_DQ_WIDTH +: DQ_GROUP_WIDTH] =
							src.wdata[g*DQ_GROUP_WIDTH + (2*ps + b)*MEM_DQ_WIDTH +: DQ_GROUP_WIDTH];
						want.wrdata_mask[g + (2*s + b)*MEM_DM_WIDTH] =
							src.dm[g + (2*ps + b)*MEM_DM_WIDTH];
					end
				end
			end
		end
		return want;
	endfunction

	task automatic check_field(input string name, input logic [127:0] want_v,
		input logic [127:0] got_v);
		test_checks++;
		assert (got_v === want_v)
		else
		begin
			$display("Fail %s at cycle %0d: expected %0h got %0h", name, cyc, want_v, got_v);
			test_errors++;
		end
	endtask

	task automatic check_outputs();
		ddio_wr_t want;
		want = expected_out(cyc);
		check_field("phy_ddio_dq", want.dq, phy_ddio_dq);
		check_field("phy_ddio_wrdata_mask", 128'(want.wrdata_mask), 128'(phy_ddio_wrdata_mask));
		check_field("phy_ddio_wrdata_en", 128'(want.wrdata_en), 128'(phy_ddio_wrdata_en));
		check_field("phy_ddio_dqs_en", 128'(want.dqs_en), 128'(phy_ddio_dqs_en));
		check_field("phy_ddio_oct_ena", 128'(want.oct_ena), 128'(phy_ddio_oct_ena));
	endtask

	// drives one afi cycle on the rising edge and compares the outputs at the falling edge
	task automatic drive_cycle(input afi_wr_t w, input logic [AFI_DQS_WIDTH-1:0] force_v,
		input logic wr, input logic grp, input shift_t sh);
		@(posedge pll_afi_clk);
		afi_wdata <= w.wdata;
		afi_wdata_valid <= w.wdata_valid;
		afi_dm <= w.dm;
		afi_dqs_en <= w.dqs_en;
		force_oct_off <= force_v;
		cfg_wr <= wr;
		cfg_group <= grp;
		cfg_shift <= sh;
		// a strobe from the previous cycle is in use from this cycle on
		if (pend_wr)
			model_shift[pend_grp] = pend_shift;
		pend_wr = wr;
		pend_grp = grp;
		pend_shift = sh;
		cyc = cyc + 1;
		hist[cyc] = w;
		force_now = force_v;
		@(negedge pll_afi_clk);
		check_outputs();
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++)
			drive_cycle('0, '0, 1'b0, 1'b0, 2'd0);
	endtask

	task automatic write_shift(input logic grp, input shift_t sh);
		drive_cycle('0, '0, 1'b1, grp, sh);
	endtask

	task automatic expect_oct(input logic [AFI_DQS_WIDTH-1:0] want_v);
		check_field("phy_ddio_oct_ena", 128'(want_v), 128'(phy_ddio_oct_ena));
	endtask

	task automatic release_reset();
		arst_n <= 1'b1;
	endtask

	task automatic finish_test(input string name);
		$display("test %s done: %0d checks, %0d errors", name, test_checks, test_errors);
		total_checks = total_checks + test_checks;
		total_errors = total_errors + test_errors;
		tests_run++;
		test_checks = 0;
		test_errors = 0;
	endtask

	// ************************************************************
	// directed tests
	// ************************************************************

	task automatic test_reset_state();
		for (int i = 0; i < 3; i++)
		begin
			idle_cycles(1);
			check_field("phy_ddio_dqs_en", 128'h0, 128'(phy_ddio_dqs_en));
			check_field("phy_ddio_wrdata_en", 128'h0, 128'(phy_ddio_wrdata_en));
			expect_oct(8'hff);
		end
		finish_test("reset_state");
	endtask

	task automatic test_zero_shift();
		for (int i = 0; i < 8; i++)
		begin
			drive_cycle(random_word(), '0, 1'b0, 1'b0, 2'd0);
			check_field("phy_ddio_dq", hist[cyc - PIPE_STAGES].wdata, phy_ddio_dq);
			check_field("phy_ddio_wrdata_mask", 128'(hist[cyc - PIPE_STAGES].dm),
				128'(phy_ddio_wrdata_mask));
			check_field("phy_ddio_wrdata_en", 128'(hist[cyc - PIPE_STAGES].wdata_valid),
				128'(phy_ddio_wrdata_en));
			check_field("phy_ddio_dqs_en", 128'(hist[cyc - PIPE_STAGES].dqs_en),
				128'(phy_ddio_dqs_en));
		end
		finish_test("zero_shift");
	endtask

	task automatic test_group_deskew();
		write_shift(1'b0, 2'd1);
		write_shift(1'b1, 2'd3);
		for (int i = 0; i < 10; i++)
			drive_cycle(random_word(), '0, 1'b0, 1'b0, 2'd0);
		idle_cycles(3);
		finish_test("group_deskew");
	endtask

	task automatic test_oct_window();
		afi_wr_t w;
		write_shift(1'b0, 2'd0);
		write_shift(1'b1, 2'd0);
		idle_cycles(3);
		w = '0;
		// pulse in slot 0 opens the window from slot 3 of the cycle before
		w.dqs_en = 8'b0000_0011;
		drive_cycle(w, '0, 1'b0, 1'b0, 2'd0);
		idle_cycles(1);
		expect_oct(8'h3f);
		idle_cycles(1);
		expect_oct(8'hf0);
		idle_cycles(2);
		// pulse in slot 3 closes the window in slot 0 of the next cycle
		w.dqs_en = 8'b1100_0000;
		drive_cycle(w, '0, 1'b0, 1'b0, 2'd0);
		idle_cycles(1);
		expect_oct(8'hff);
		idle_cycles(1);
		expect_oct(8'h0f);
		idle_cycles(1);
		expect_oct(8'hfc);
		idle_cycles(1);
		expect_oct(8'hff);
		drive_cycle('0, 8'hff, 1'b0, 1'b0, 2'd0);
		expect_oct(8'h00);
		drive_cycle('0, 8'h55, 1'b0, 1'b0, 2'd0);
		expect_oct(8'haa);
		idle_cycles(1);
		expect_oct(8'hff);
		finish_test("oct_window");
	endtask

	task automatic test_random_stream();
		logic [31:0] r;
		for (int i = 0; i < 200; i++)
		begin
			r = next_random();
			drive_cycle(random_word(), '0, r[3:0] == 4'd0, r[4], r[6:5]);
		end
		idle_cycles(3);
		finish_test("random_stream");
	endtask

	initial
	begin
		arst_n = 1'b0;
		afi_wdata = '0;
		afi_wdata_valid = '0;
		afi_dm = '0;
		afi_dqs_en = '0;
		force_oct_off = '0;
		cfg_wr = 1'b0;
		cfg_group = '0;
		cfg_shift = '0;
		force_now = '0;
		pend_wr = 1'b0;
		pend_grp = 1'b0;
		pend_shift = '0;
		for (int g = 0; g < MEM_WRITE_DQS_WIDTH; g++)
			model_shift[g] = '0;
		rng_state = 32'hc282_73a7;
		cyc = -1;
		cycle_count = 0;
		test_checks = 0;
		test_errors = 0;
		total_checks = 0;
		total_errors = 0;
		tests_run = 0;
		repeat (2) @(posedge pll_afi_clk);
		release_reset();

		test_reset_state();
		test_zero_shift();
		test_group_deskew();
		test_oct_window();
		test_random_stream();

		total_errors = total_errors + phy_write_top_inst.phy_write_properties_inst.assert_fails;
		$display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* tb/phy_write_properties.sv */
// write path port checks
// termination and enable rules bound onto the phy write top level
module phy_write_properties (
	input logic                                  pll_afi_clk,
	input logic                                  arst_n,
	input logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0] afi_dqs_en,
	input logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0] afi_wdata_valid,
	input logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0] force_oct_off,
	input logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0] phy_ddio_dqs_en,
	input logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0] phy_ddio_wrdata_en,
	input logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0] phy_ddio_oct_ena
);
	timeunit 1ns;
	timeprecision 1ps;

	int   assert_fails = 0;
	logic afi_seen_r;

	// set once any write enable has reached the afi side
	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
			afi_seen_r <= 1'b0;
		else if (|afi_dqs_en || |afi_wdata_valid)
			afi_seen_r <= 1'b1;
	end

	forced_off_a: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		(force_oct_off & phy_ddio_oct_ena) == '0)
	else
	begin
		$error("oct_ena high on a bit with force_oct_off set");
		assert_fails++;
	end

	dqs_in_window_a: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		(phy_ddio_dqs_en & phy_ddio_oct_ena) == '0)
	else
	begin
		$error("dqs_en high while oct_ena is still high");
		assert_fails++;
	end

	quiet_after_reset_a: assert property (@(posedge pll_afi_clk) disable iff (!arst_n)
		!afi_seen_r |-> (phy_ddio_dqs_en == '0 && phy_ddio_wrdata_en == '0))
	else
	begin
		$error("write enables high before any afi write request");
		assert_fails++;
	end

endmodule

/* rtl/phy_write_top.sv */
// phy write path top level
// joins the sequencer shift registers with the write datapath
module phy_write_top #(
	parameter int NUM_WRITE_PATH_FLOP_STAGES = 2,
	parameter int NUM_WRITE_FR_CYCLE_SHIFTS  = 4
) (
	input  logic                                                pll_afi_clk,
	input  logic                                                arst_n,
	input  logic [ddr_phy_pkg::AFI_DATA_WIDTH-1:0]              afi_wdata,
	input  logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]               afi_wdata_valid,
	input  logic [ddr_phy_pkg::AFI_DM_WIDTH-1:0]                afi_dm,
	input  logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]               afi_dqs_en,
	input  logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]               force_oct_off,
	input  logic                                                cfg_wr,
	input  logic [$clog2(ddr_phy_pkg::MEM_WRITE_DQS_WIDTH)-1:0] cfg_group,
	input  ddr_phy_pkg::shift_t                                 cfg_shift,
	output logic [ddr_phy_pkg::AFI_DATA_WIDTH-1:0]              phy_ddio_dq,
	output logic [ddr_phy_pkg::AFI_DM_WIDTH-1:0]                phy_ddio_wrdata_mask,
	output logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]               phy_ddio_wrdata_en,
	output logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]               phy_ddio_dqs_en,
	output logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]               phy_ddio_oct_ena
);
	import ddr_phy_pkg::*;

	afi_wr_t                                   afi_in;
	ddio_wr_t                                  ddio_out;
	logic [MEM_WRITE_DQS_WIDTH*$bits(shift_t)-1:0] group_shift;

	assign afi_in = '{
		dqs_en:      afi_dqs_en,
		wdata_valid: afi_wdata_valid,
		dm:          afi_dm,
		wdata:       afi_wdata
	};

	write_shift_cfg write_shift_cfg_inst (
		.pll_afi_clk (pll_afi_clk),
		.arst_n      (arst_n),
		.cfg_wr      (cfg_wr),
		.cfg_group   (cfg_group),
		.cfg_shift   (cfg_shift),
		.group_shift (group_shift)
	);

	write_datapath #(
		.NUM_WRITE_PATH_FLOP_STAGES (NUM_WRITE_PATH_FLOP_STAGES),
		.NUM_WRITE_FR_CYCLE_SHIFTS  (NUM_WRITE_FR_CYCLE_SHIFTS)
	) write_datapath_inst (
		.pll_afi_clk   (pll_afi_clk),
		.arst_n        (arst_n),
		.afi_in        (afi_in),
		.force_oct_off (force_oct_off),
		.group_shift   (group_shift),
		.ddio_out      (ddio_out)
	);

	assign phy_ddio_dq          = ddio_out.dq;
	assign phy_ddio_wrdata_mask = ddio_out.wrdata_mask;
	assign phy_ddio_wrdata_en   = ddio_out.wrdata_en;
	assign phy_ddio_dqs_en      = ddio_out.dqs_en;
	assign phy_ddio_oct_ena     = ddio_out.oct_ena;

endmodule

/* rtl/write_datapath.sv */
// write datapath
// pipes the afi write bundle, deskews each dqs group and forms the odt window
module write_datapath #(
	parameter int NUM_WRITE_PATH_FLOP_STAGES = 2,
	parameter int NUM_WRITE_FR_CYCLE_SHIFTS  = 4
) (
	input  logic                                                  pll_afi_clk,
	input  logic                                                  arst_n,
	input  ddr_phy_pkg::afi_wr_t                                  afi_in,
	input  logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]                 force_oct_off,
	input  logic [ddr_phy_pkg::MEM_WRITE_DQS_WIDTH*
		$bits(ddr_phy_pkg::shift_t)-1:0]                          group_shift,
	output ddr_phy_pkg::ddio_wr_t                                 ddio_out
);
	import ddr_phy_pkg::*;

	localparam int SHIFT_W      = $bits(shift_t);
	localparam int NUM_BEATS    = 2 * RATE_MULT;
	localparam int GRP_DQ_WIDTH = DQ_GROUP_WIDTH * NUM_BEATS;
	localparam int GRP_DM_WIDTH = DM_GROUP_WIDTH * NUM_BEATS;

	afi_wr_t                  afi_piped;
	logic [AFI_DQS_WIDTH-1:0] dqs_en_early;
	logic [AFI_DQS_WIDTH-1:0] oct_src_extended;
	logic [AFI_DQS_WIDTH-1:0] oct_window;

	// slot-major buses after the per-group shift
	logic [AFI_DATA_WIDTH-1:0] dq_post;
	logic [AFI_DM_WIDTH-1:0]   dm_post;
	logic [AFI_DQS_WIDTH-1:0]  wren_post;
	logic [AFI_DQS_WIDTH-1:0]  dqs_post;
	logic [AFI_DQS_WIDTH-1:0]  window_post;

	write_path_pipe #(
		.NUM_STAGES (NUM_WRITE_PATH_FLOP_STAGES)
	) write_path_pipe_inst (
		.pll_afi_clk  (pll_afi_clk),
		.arst_n       (arst_n),
		.afi_in       (afi_in),
		.afi_out      (afi_piped),
		.dqs_en_early (dqs_en_early)
	);

	// ************************************************************
	// termination window
	// ************************************************************

	// the early tap runs one cycle ahead, so widening by two slots and
	// delaying by three leaves one slot of margin on either side
	fr_cycle_extender #(
		.WIDTH (AFI_DQS_WIDTH)
	) oct_src_extender (
		.pll_afi_clk (pll_afi_clk),
		.arst_n      (arst_n),
		.datain      (dqs_en_early),
		.dataout     (oct_src_extended)
	);

	fr_cycle_shifter #(
		.WIDTH (AFI_DQS_WIDTH)
	) oct_src_shifter (
		.pll_afi_clk (pll_afi_clk),
		.arst_n      (arst_n),
		.shift_by    (shift_t'(3)),
		.datain      (oct_src_extended),
		.dataout     (oct_window)
	);

	// ************************************************************
	// per-group deskew
	// ************************************************************

	for (genvar g = 0; g < MEM_WRITE_DQS_WIDTH; g++)
	begin : grp_gen
		shift_t                  grp_shift;
		logic [GRP_DQ_WIDTH-1:0] grp_dq_pre;
		logic [GRP_DQ_WIDTH-1:0] grp_dq;
		logic [GRP_DM_WIDTH-1:0] grp_dm_pre;
		logic [GRP_DM_WIDTH-1:0] grp_dm;
		logic [RATE_MULT-1:0]    grp_wren_pre;
		logic [RATE_MULT-1:0]    grp_wren;
		logic [RATE_MULT-1:0]    grp_dqs_pre;
		logic [RATE_MULT-1:0]    grp_dqs;
		logic [RATE_MULT-1:0]    grp_win_pre;
		logic [RATE_MULT-1:0]    grp_win;

		if (NUM_WRITE_FR_CYCLE_SHIFTS < 4)
		begin : fixed_shift_gen
			assign grp_shift = shift_t'(NUM_WRITE_FR_CYCLE_SHIFTS);
		end
		else
		begin : seq_shift_gen
			assign grp_shift = group_shift[g*SHIFT_W +: SHIFT_W];
		end

		// gather this group's bits beat by beat, and scatter them back
		for (genvar t = 0; t < NUM_BEATS; t++)
		begin : beat_gen
			assign grp_dq_pre[t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
				afi_piped.wdata[g*DQ_GROUP_WIDTH + t*MEM_DQ_WIDTH +: DQ_GROUP_WIDTH];
			assign dq_post[g*DQ_GROUP_WIDTH + t*MEM_DQ_WIDTH +: DQ_GROUP_WIDTH] =
				grp_dq[t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			assign grp_dm_pre[t*DM_GROUP_WIDTH +: DM_GROUP_WIDTH] =
				afi_piped.dm[g*DM_GROUP_WIDTH + t*MEM_DM_WIDTH +: DM_GROUP_WIDTH];
			assign dm_post[g*DM_GROUP_WIDTH + t*MEM_DM_WIDTH +: DM_GROUP_WIDTH] =
				grp_dm[t*DM_GROUP_WIDTH +: DM_GROUP_WIDTH];
		end

		// control buses carry one bit per slot and group
		for (genvar s = 0; s < RATE_MULT; s++)
		begin : slot_gen
			assign grp_wren_pre[s] = afi_piped.wdata_valid[g + s*MEM_WRITE_DQS_WIDTH];
			assign grp_dqs_pre[s]  = afi_piped.dqs_en[g + s*MEM_WRITE_DQS_WIDTH];
			assign grp_win_pre[s]  = oct_window[g + s*MEM_WRITE_DQS_WIDTH];
			assign wren_post[g + s*MEM_WRITE_DQS_WIDTH]   = grp_wren[s];
			assign dqs_post[g + s*MEM_WRITE_DQS_WIDTH]    = grp_dqs[s];
			assign window_post[g + s*MEM_WRITE_DQS_WIDTH] = grp_win[s];
		end

		fr_cycle_shifter #(.WIDTH (GRP_DQ_WIDTH)) dq_shifter (
			.pll_afi_clk (pll_afi_clk), .arst_n (arst_n), .shift_by (grp_shift),
			.datain (grp_dq_pre), .dataout (grp_dq)
		);
		fr_cycle_shifter #(.WIDTH (GRP_DM_WIDTH)) dm_shifter (
			.pll_afi_clk (pll_afi_clk), .arst_n (arst_n), .shift_by (grp_shift),
			.datain (grp_dm_pre), .dataout (grp_dm)
		);
		fr_cycle_shifter #(.WIDTH (RATE_MULT)) wren_shifter (
			.pll_afi_clk (pll_afi_clk), .arst_n (arst_n), .shift_by (grp_shift),
			.datain (grp_wren_pre), .dataout (grp_wren)
		);
		fr_cycle_shifter #(.WIDTH (RATE_MULT)) dqs_shifter (
			.pll_afi_clk (pll_afi_clk), .arst_n (arst_n), .shift_by (grp_shift),
			.datain (grp_dqs_pre), .dataout (grp_dqs)
		);
		fr_cycle_shifter #(.WIDTH (RATE_MULT)) win_shifter (
			.pll_afi_clk (pll_afi_clk), .arst_n (arst_n), .shift_by (grp_shift),
			.datain (grp_win_pre), .dataout (grp_win)
		);
	end

	// force_oct_off acts in the current cycle, not through the shift
	assign ddio_out = '{
		oct_ena:     ~window_post & ~force_oct_off,
		dqs_en:      dqs_post,
		wrdata_en:   wren_post,
		wrdata_mask: dm_post,
		dq:          dq_post
	};

endmodule

/* rtl/write_shift_cfg.sv */
// write deskew configuration registers
// holds the slot shift per dqs group as written by the sequencer
module write_shift_cfg (
	input  logic                                                  pll_afi_clk,
	input  logic                                                  arst_n,
	input  logic                                                  cfg_wr,
	input  logic [$clog2(ddr_phy_pkg::MEM_WRITE_DQS_WIDTH)-1:0]   cfg_group,
	input  ddr_phy_pkg::shift_t                                   cfg_shift,
	output logic [ddr_phy_pkg::MEM_WRITE_DQS_WIDTH*
		$bits(ddr_phy_pkg::shift_t)-1:0]                          group_shift
);
	import ddr_phy_pkg::*;

	localparam int SHIFT_W = $bits(shift_t);

	shift_t shift_r [MEM_WRITE_DQS_WIDTH];

	// the addressed group takes the new shift on the strobe edge
	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int g = 0; g < MEM_WRITE_DQS_WIDTH; g++)
				shift_r[g] <= '0;
		end
		else if (cfg_wr)
		begin
			shift_r[cfg_group] <= cfg_shift;
		end
	end

	// group 0 sits in the low bits
	for (genvar g = 0; g < MEM_WRITE_DQS_WIDTH; g++)
	begin : out_gen
		assign group_shift[g*SHIFT_W +: SHIFT_W] = shift_r[g];
	end

endmodule

/* rtl/write_path_pipe.sv */
// write path flop pipeline
// delays the afi write bundle by a set number of afi cycles
module write_path_pipe #(
	parameter int NUM_STAGES = 2
) (
	input  logic                                   pll_afi_clk,
	input  logic                                   arst_n,
	input  ddr_phy_pkg::afi_wr_t                   afi_in,
	output ddr_phy_pkg::afi_wr_t                   afi_out,
	output logic [ddr_phy_pkg::AFI_DQS_WIDTH-1:0]  dqs_en_early
);
	import ddr_phy_pkg::*;

	afi_wr_t stage_r [NUM_STAGES];

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < NUM_STAGES; i++)
				stage_r[i] <= '0;
		end
		else
		begin
			stage_r[0] <= afi_in;
			for (int i = 1; i < NUM_STAGES; i++)
				stage_r[i] <= stage_r[i-1];
		end
	end

	assign afi_out = stage_r[NUM_STAGES-1];

	// termination has to open a cycle ahead of the data, so it taps
	// the stage before the last one
	if (NUM_STAGES == 1)
	begin : tap_input_gen
		assign dqs_en_early = afi_in.dqs_en;
	end
	else
	begin : tap_stage_gen
		assign dqs_en_early = stage_r[NUM_STAGES-2].dqs_en;
	end

endmodule

/* rtl/fr_cycle_extender.sv */
// full-rate cycle extender
// stretches every high slot over the two slots that follow it
module fr_cycle_extender #(
	parameter int WIDTH = 8
) (
	input  logic             pll_afi_clk,
	input  logic             arst_n,
	input  logic [WIDTH-1:0] datain,
	output logic [WIDTH-1:0] dataout
);
	import ddr_phy_pkg::*;

	localparam int SLOT_WIDTH = WIDTH / RATE_MULT;

	logic [WIDTH-1:0]   prev_r;
	logic [2*WIDTH-1:0] joined;
	logic [WIDTH-1:0]   back_one;
	logic [WIDTH-1:0]   back_two;

	// the previous word supplies the slots before slot 0
	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
			prev_r <= '0;
		else
			prev_r <= datain;
	end

	assign joined = {datain, prev_r};

	// the same word seen one and two slots earlier
	assign back_one = joined[(RATE_MULT-1)*SLOT_WIDTH +: WIDTH];
	assign back_two = joined[(RATE_MULT-2)*SLOT_WIDTH +: WIDTH];

	// slot s is high if slot s, s-1 or s-2 was high
	assign dataout = datain | back_one | back_two;

endmodule

/* rtl/fr_cycle_shifter.sv */
// full-rate cycle shifter
// moves a slot-packed word later by 0 to 3 full-rate slots
module fr_cycle_shifter #(
	parameter int WIDTH = 8
) (
	input  logic                pll_afi_clk,
	input  logic                arst_n,
	input  ddr_phy_pkg::shift_t shift_by,
	input  logic [WIDTH-1:0]    datain,
	output logic [WIDTH-1:0]    dataout
);
	import ddr_phy_pkg::*;

	localparam int SLOT_WIDTH = WIDTH / RATE_MULT;

	// word seen in the previous afi cycle
	logic [WIDTH-1:0] prev_r;

	// previous word in the low half, current word in the high half
	logic [2*WIDTH-1:0] joined;

	always_ff @(posedge pll_afi_clk or negedge arst_n)
	begin
		if (!arst_n)
			prev_r <= '0;
		else
			prev_r <= datain;
	end

	assign joined = {datain, prev_r};

	// a window of one word starting k slots below the current word
	// pulls the top k slots of the previous cycle into the low slots
	always_comb
	begin
		case (shift_by)
			2'd0:
				dataout = datain;
			2'd1:
				dataout = joined[(RATE_MULT-1)*SLOT_WIDTH +: WIDTH];
			2'd2:
				dataout = joined[(RATE_MULT-2)*SLOT_WIDTH +: WIDTH];
			default:
				dataout = joined[(RATE_MULT-3)*SLOT_WIDTH +: WIDTH];
		endcase
	end

endmodule

/* rtl/ddr_phy_pkg.sv */
// ddr3 quarter-rate phy write path definitions
// memory and afi widths, rate constants and the write bundles
package ddr_phy_pkg;

	// ************************************************************
	// rate and memory interface widths
	// ************************************************************

	// full-rate slots carried by one afi cycle
	localparam int RATE_MULT = 4;

	localparam int MEM_DQ_WIDTH        = 16;
	localparam int MEM_DM_WIDTH        = 2;
	localparam int MEM_WRITE_DQS_WIDTH = 2;

	// bits that belong to one dqs group
	localparam int DQ_GROUP_WIDTH = 8;
	localparam int DM_GROUP_WIDTH = 1;

	// ************************************************************
	// afi side widths
	// ************************************************************

	// data and mask carry two ddr beats per slot in slot-major order
	localparam int AFI_DATA_WIDTH = 128;
	localparam int AFI_DM_WIDTH   = 16;

	// one bit per slot and group
	localparam int AFI_DQS_WIDTH = 8;

	// number of full-rate slots a group is delayed by
	typedef logic [1:0] shift_t;

	// write request as it arrives from the controller
	typedef struct packed {
		logic [AFI_DQS_WIDTH-1:0]  dqs_en;
		logic [AFI_DQS_WIDTH-1:0]  wdata_valid;
		logic [AFI_DM_WIDTH-1:0]   dm;
		logic [AFI_DATA_WIDTH-1:0] wdata;
	} afi_wr_t;

	// write fields handed to the ddio output cells
	typedef struct packed {
		logic [AFI_DQS_WIDTH-1:0]  oct_ena;
		logic [AFI_DQS_WIDTH-1:0]  dqs_en;
		logic [AFI_DQS_WIDTH-1:0]  wrdata_en;
		logic [AFI_DM_WIDTH-1:0]   wrdata_mask;
		logic [AFI_DATA_WIDTH-1:0] dq;
	} ddio_wr_t;

endpackage
